/* common/dispatch_config.svh */
//##########################################################################
// dispatch stage configuration macros
// group width, checkpoint count, register and field widths
// back-end queue depths with their index widths
//##########################################################################

`ifndef DISPATCH_CONFIG_SVH
`define DISPATCH_CONFIG_SVH

// group and checkpoints
`define DISPATCH_WIDTH        4     // lanes per group
`define CHECKPOINTS           8     // branch mask width
`define CHECKPOINTS_LOG       3     // checkpoint tag width

// instruction fields
`define SIZE_PC               32
`define SIZE_RMT_LOG          5     // logical register index
`define SIZE_PHYSICAL_LOG     7     // physical register index
`define SIZE_IMMEDIATE        16

// back-end queues, count inputs are one bit wider than the index
`define SIZE_LSQ              16    // load queue and store queue depth
`define SIZE_LSQ_LOG          4
`define SIZE_ISSUEQ           32
`define SIZE_ISSUEQ_LOG       5
`define SIZE_ACTIVELIST       64
`define SIZE_ACTIVELIST_LOG   6

`endif

/* common/dispatchPkg.sv */
//##########################################################################
// dispatch types
// instruction type enum, renamed instruction packet
// issue queue, active list and load-store queue packets, per-group arrays
//##########################################################################

`include "dispatch_config.svh"

package dispatchPkg;

  typedef enum logic [2:0] {
    ALU     = 3'd0,
    COMPLEX = 3'd1,  // multi-cycle integer
    BRANCH  = 3'd2,
    LOAD    = 3'd3,
    STORE   = 3'd4
  } instType_t;

  typedef logic [`CHECKPOINTS-1:0] branchMask_t;

  // one instruction as it leaves rename
  typedef struct packed {
    logic [`SIZE_PC-1:0]           pc;
    instType_t                     instType;
    branchMask_t                   branchMask;
    logic [`CHECKPOINTS_LOG-1:0]   ctrlTag;     // own checkpoint if a branch
    logic [`SIZE_RMT_LOG-1:0]      logDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] oldPhyDest;  // freed at retire
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
  } renamedPkt_t;

  typedef struct packed {
    instType_t                     instType;
    logic                          isLoad;
    logic                          isStore;
    branchMask_t                   branchMask;  // verified bit already cleared
    logic [`CHECKPOINTS_LOG-1:0]   ctrlTag;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc1;
    logic [`SIZE_PHYSICAL_LOG-1:0] phySrc2;
    logic [`SIZE_IMMEDIATE-1:0]    immediate;
    logic [`SIZE_PC-1:0]           pc;
  } iqPkt_t;

  typedef struct packed {
    logic                          isLoad;
    logic                          isStore;
    logic [`SIZE_PC-1:0]           pc;
    logic [`SIZE_RMT_LOG-1:0]      logDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] phyDest;
    logic [`SIZE_PHYSICAL_LOG-1:0] oldPhyDest;
    logic                          isBranch;
  } alPkt_t;

  typedef struct packed {
    branchMask_t branchMask;
    logic        isStore;
    logic        isLoad;
  } lsqPkt_t;

  // one entry per lane
  typedef renamedPkt_t [`DISPATCH_WIDTH-1:0] renamedGroup_t;
  typedef iqPkt_t      [`DISPATCH_WIDTH-1:0] iqGroup_t;
  typedef alPkt_t      [`DISPATCH_WIDTH-1:0] alGroup_t;
  typedef lsqPkt_t     [`DISPATCH_WIDTH-1:0] lsqGroup_t;
  typedef branchMask_t [`DISPATCH_WIDTH-1:0] maskGroup_t;

endpackage

/* common/dispatchIf.sv */
//##########################################################################
// formed back-end packets of one group
// driven by the packet former, sampled by the dispatch latch
//##########################################################################

`timescale 1ns/100ps

`include "dispatch_config.svh"

interface dispatchPktIf
  import dispatchPkg::*;
();

  iqGroup_t   iqPkt;        // issue queue entries
  alGroup_t   alPkt;        // active list entries
  lsqGroup_t  lsqPkt;       // load-store queue entries
  maskGroup_t updatedMask;  // masks after branch verification

  // combinational producer side
  modport former (
    output iqPkt,
    output alPkt,
    output lsqPkt,
    output updatedMask
  );

  // sampled at the accepting edge
  modport latch (
    input iqPkt,
    input alPkt,
    input lsqPkt,
    input updatedMask
  );

endinterface

/* resourceCheck/resourceCheck.sv */
//##########################################################################
// resourceCheck
// load and store count of the incoming group, back-end space check
//##########################################################################

`timescale 1ns/100ps

`include "dispatch_config.svh"

module resourceCheck
  import dispatchPkg::*;
(
  input  renamedGroup_t                 renamed_i,
  input  logic [`SIZE_LSQ_LOG:0]        loadQueueCnt_i,   // current load queue occupancy
  input  logic [`SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt_i,
  output logic                          stall_o
);

  // one extra bit on every sum so the add never wraps
  localparam int cntW = $clog2(`DISPATCH_WIDTH + 1);
  localparam int lsqSumW = `SIZE_LSQ_LOG + 2;
  localparam int iqSumW = `SIZE_ISSUEQ_LOG + 2;
  localparam int alSumW = `SIZE_ACTIVELIST_LOG + 2;

  localparam logic [lsqSumW-1:0] lsqDepth = lsqSumW'(`SIZE_LSQ);
  localparam logic [iqSumW-1:0] iqDepth = iqSumW'(`SIZE_ISSUEQ);
  localparam logic [alSumW-1:0] alDepth = alSumW'(`SIZE_ACTIVELIST);

  logic [cntW-1:0]    loadCnt;
  logic [cntW-1:0]    storeCnt;
  logic [lsqSumW-1:0] loadSum;
  logic [lsqSumW-1:0] storeSum;
  logic [iqSumW-1:0]  issueSum;
  logic [alSumW-1:0]  activeSum;
  logic               loadStall;
  logic               storeStall;
  logic               issueStall;
  logic               activeStall;

  //########################################################################
  // memory instructions in the group
  //########################################################################
  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (renamed_i[i].instType == LOAD) begin
        loadCnt = loadCnt + 1'b1;
      end
      if (renamed_i[i].instType == STORE) begin
        storeCnt = storeCnt + 1'b1;
      end
    end
  end

  //########################################################################
  // space check, a full queue after dispatch is still fine
  //########################################################################
  assign loadSum   = lsqSumW'(loadQueueCnt_i) + lsqSumW'(loadCnt);
  assign storeSum  = lsqSumW'(storeQueueCnt_i) + lsqSumW'(storeCnt);
  // every lane takes an issue queue and an active list slot
  assign issueSum  = iqSumW'(issueQueueCnt_i) + iqSumW'(`DISPATCH_WIDTH);
  assign activeSum = alSumW'(activeListCnt_i) + alSumW'(`DISPATCH_WIDTH);

  assign loadStall   = (loadSum > lsqDepth);
  assign storeStall  = (storeSum > lsqDepth);
  assign issueStall  = (issueSum > iqDepth);
  assign activeStall = (activeSum > alDepth);

  assign stall_o = loadStall | storeStall | issueStall | activeStall;

endmodule

/* packetFormer/packetFormer.sv */
//##########################################################################
// packetFormer
// clears the verified checkpoint from each lane's branch mask
// splits every lane into issue queue, active list and LSQ packets
//##########################################################################

`timescale 1ns/100ps

`include "dispatch_config.svh"

module packetFormer
  import dispatchPkg::*;
(
  input  renamedGroup_t               renamed_i,
  input  logic                        ctrlVerified_i,     // a branch resolved correctly
  input  logic [`CHECKPOINTS_LOG-1:0] ctrlVerifiedTag_i,  // its checkpoint
  dispatchPktIf.former                pkt
);

  branchMask_t                clearMask;  // one-hot, zero when nothing verified
  maskGroup_t                 newMask;
  logic [`DISPATCH_WIDTH-1:0] isLoad;
  logic [`DISPATCH_WIDTH-1:0] isStore;
  logic [`DISPATCH_WIDTH-1:0] isBranch;

  //########################################################################
  // branch mask update and type decode
  //########################################################################
  assign clearMask = {{(`CHECKPOINTS-1){1'b0}}, ctrlVerified_i} << ctrlVerifiedTag_i;

  // same rule on every lane
  always_comb begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      newMask[i]  = renamed_i[i].branchMask & ~clearMask;
      isLoad[i]   = (renamed_i[i].instType == LOAD);
      isStore[i]  = (renamed_i[i].instType == STORE);
      isBranch[i] = (renamed_i[i].instType == BRANCH);
    end
  end

  //########################################################################
  // back-end packets
  //########################################################################
  always_comb begin
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      // issue queue needs operands and the wakeup tags
      pkt.iqPkt[i].instType   = renamed_i[i].instType;
      pkt.iqPkt[i].isLoad     = isLoad[i];
      pkt.iqPkt[i].isStore    = isStore[i];
      pkt.iqPkt[i].branchMask = newMask[i];
      pkt.iqPkt[i].ctrlTag    = renamed_i[i].ctrlTag;
      pkt.iqPkt[i].phyDest    = renamed_i[i].phyDest;
      pkt.iqPkt[i].phySrc1    = renamed_i[i].phySrc1;
      pkt.iqPkt[i].phySrc2    = renamed_i[i].phySrc2;
      pkt.iqPkt[i].immediate  = renamed_i[i].immediate;
      pkt.iqPkt[i].pc         = renamed_i[i].pc;

      // active list keeps what retire and recovery need
      pkt.alPkt[i].isLoad     = isLoad[i];
      pkt.alPkt[i].isStore    = isStore[i];
      pkt.alPkt[i].pc         = renamed_i[i].pc;
      pkt.alPkt[i].logDest    = renamed_i[i].logDest;
      pkt.alPkt[i].phyDest    = renamed_i[i].phyDest;
      pkt.alPkt[i].oldPhyDest = renamed_i[i].oldPhyDest;
      pkt.alPkt[i].isBranch   = isBranch[i];

      pkt.lsqPkt[i].branchMask = newMask[i];  // for squash on mispredict
      pkt.lsqPkt[i].isStore    = isStore[i];
      pkt.lsqPkt[i].isLoad     = isLoad[i];

      // back to the rename pipeline register while stalled
      pkt.updatedMask[i] = newMask[i];
    end
  end

endmodule

/* source/dispatchLatch.sv */
//##########################################################################
// dispatchLatch
// acceptance from rename ready, stall and recovery
// output register for the dispatched group and its valid pulse
//##########################################################################

`timescale 1ns/100ps

`include "dispatch_config.svh"

module dispatchLatch
  import dispatchPkg::*;
(
  input  logic         clk,
  input  logic         rst_i,
  input  logic         renameReady_i,    // rename holds a group
  input  logic         flagRecoverEX_i,  // mispredict recovery in progress
  input  logic         stall_i,          // some queue lacks space
  dispatchPktIf.latch  pkt,
  output logic         backEndReady_o,
  output logic         dispatchValid_o,
  output iqGroup_t     iqPkt_o,
  output alGroup_t     alPkt_o,
  output lsqGroup_t    lsqPkt_o,
  output maskGroup_t   updatedBranchMask_o
);

  logic accept;

  //########################################################################
  // handshake
  //########################################################################
  assign accept = renameReady_i & ~stall_i & ~flagRecoverEX_i;

  assign backEndReady_o = accept;  // same cycle, rename advances on it

  // valid for one cycle per accepting edge
  always_ff @(posedge clk) begin
    if (rst_i) begin
      dispatchValid_o <= 1'b0;
    end else begin
      dispatchValid_o <= accept;
    end
  end

  //########################################################################
  // group register
  //########################################################################
  always_ff @(posedge clk) begin
    if (accept) begin
      iqPkt_o  <= pkt.iqPkt;
      alPkt_o  <= pkt.alPkt;
      lsqPkt_o <= pkt.lsqPkt;
    end
  end

  // masks of a held group, not registered here
  assign updatedBranchMask_o = pkt.updatedMask;

endmodule

/* source/dispatchTop.sv */
//##########################################################################
// dispatchTop
// dispatch stage of the four-wide core
// capacity check and packet former side by side, then the output latch
//##########################################################################

`timescale 1ns/100ps

`include "dispatch_config.svh"

module dispatchTop
  import dispatchPkg::*;
(
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic                          renameReady_i,
  input  logic                          flagRecoverEX_i,
  input  logic                          ctrlVerified_i,
  input  logic [`CHECKPOINTS_LOG-1:0]   ctrlVerifiedTag_i,
  input  renamedGroup_t                 renamedPacket_i,
  input  logic [`SIZE_LSQ_LOG:0]        loadQueueCnt_i,
  input  logic [`SIZE_LSQ_LOG:0]        storeQueueCnt_i,
  input  logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i,
  input  logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt_i,
  output iqGroup_t                      iqPacket_o,
  output alGroup_t                      alPacket_o,
  output lsqGroup_t                     lsqPacket_o,
  output maskGroup_t                    updatedBranchMask_o,
  output logic                          dispatchValid_o,
  output logic                          backEndReady_o,
  output logic                          stallfrontEnd_o
);

  logic stall;

  dispatchPktIf u_pktIf ();

  resourceCheck u_resourceCheck (
    .renamed_i       (renamedPacket_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .stall_o         (stall)
  );

  packetFormer u_packetFormer (
    .renamed_i         (renamedPacket_i),
    .ctrlVerified_i    (ctrlVerified_i),
    .ctrlVerifiedTag_i (ctrlVerifiedTag_i),
    .pkt               (u_pktIf.former)
  );

  dispatchLatch u_dispatchLatch (
    .clk                 (clk),
    .rst_i               (rst_i),
    .renameReady_i       (renameReady_i),
    .flagRecoverEX_i     (flagRecoverEX_i),
    .stall_i             (stall),
    .pkt                 (u_pktIf.latch),
    .backEndReady_o      (backEndReady_o),
    .dispatchValid_o     (dispatchValid_o),
    .iqPkt_o             (iqPacket_o),
    .alPkt_o             (alPacket_o),
    .lsqPkt_o            (lsqPacket_o),
    .updatedBranchMask_o (updatedBranchMask_o)
  );

  assign stallfrontEnd_o = stall;  // holds decode and rename

endmodule

/* verif/dispatch_props.sv */
//##########################################################################
// concurrent checks on the dispatch latch handshake
// bound into every dispatchLatch instance
//##########################################################################

`timescale 1ns/100ps

module dispatchProps (
  input logic clk,
  input logic rst_i,
  input logic flagRecoverEX_i,
  input logic stall_i,
  input logic backEndReady_o,
  input logic dispatchValid_o
);

  // no pulse without an accepting edge
  noValidWithoutAccept: assert property (
    @(posedge clk) disable iff (rst_i) !backEndReady_o |=> !dispatchValid_o
  ) else $error("dispatchValid_o rose after a non-accepting edge");

  // stall and recovery both block rename
  noReadyWhenBlocked: assert property (
    @(posedge clk) (stall_i || flagRecoverEX_i) |-> !backEndReady_o
  ) else $error("backEndReady_o high during stall or recovery");

  validClearedByReset: assert property (
    @(posedge clk) rst_i |=> !dispatchValid_o
  ) else $error("dispatchValid_o high after a reset edge");

endmodule

bind dispatchLatch dispatchProps u_props (
  .clk             (clk),
  .rst_i           (rst_i),
  .flagRecoverEX_i (flagRecoverEX_i),
  .stall_i         (stall_i),
  .backEndReady_o  (backEndReady_o),
  .dispatchValid_o (dispatchValid_o)
);

/* verif/dispatchTb.sv */
//##########################################################################
// dispatch stage testbench
// directed tests for reset, packet split, queue capacity limits,
// branch verification and recovery
//##########################################################################

`timescale 1ns/100ps

`include "dispatch_config.svh"

module dispatchTb
  import dispatchPkg::*;
();

  localparam int validTimeout = 16;  // cycles to wait for a valid pulse

  logic                          clk;
  logic                          rst_i;
  logic                          renameReady_i;
  logic                          flagRecoverEX_i;
  logic                          ctrlVerified_i;
  logic [`CHECKPOINTS_LOG-1:0]   ctrlVerifiedTag_i;
  renamedGroup_t                 renamedPacket_i;
  logic [`SIZE_LSQ_LOG:0]        loadQueueCnt_i;
  logic [`SIZE_LSQ_LOG:0]        storeQueueCnt_i;
  logic [`SIZE_ISSUEQ_LOG:0]     issueQueueCnt_i;
  logic [`SIZE_ACTIVELIST_LOG:0] activeListCnt_i;
  iqGroup_t                      iqPacket_o;
  alGroup_t                      alPacket_o;
  lsqGroup_t                     lsqPacket_o;
  maskGroup_t                    updatedBranchMask_o;
  logic                          dispatchValid_o;
  logic                          backEndReady_o;
  logic                          stallfrontEnd_o;
  int                            errorCount;
  int                            checkCount;
  renamedGroup_t                 grp;

  dispatchTop u_dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //########################################################################
  // checking helpers
  //########################################################################
  task automatic checkBit(input string name, input logic got, input logic exp);
    checkCount++;
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      errorCount++;
    end
  endtask

  task automatic checkWord(input string name, input logic [127:0] got, input logic [127:0] exp);
    checkCount++;
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      errorCount++;
    end
  endtask

  function automatic renamedGroup_t makeGroup(input instType_t t0, t1, t2, t3);
    renamedGroup_t g;
    instType_t     types [`DISPATCH_WIDTH];
    int            i;
    types = '{t0, t1, t2, t3};
    for (i = 0; i < `DISPATCH_WIDTH; i++) begin
      g[i].pc         = $urandom();
      g[i].instType   = types[i];
      g[i].branchMask = `CHECKPOINTS'($urandom());
      g[i].ctrlTag    = `CHECKPOINTS_LOG'($urandom());
      g[i].logDest    = `SIZE_RMT_LOG'($urandom());
      g[i].phyDest    = `SIZE_PHYSICAL_LOG'($urandom());
      g[i].oldPhyDest = `SIZE_PHYSICAL_LOG'($urandom());
      g[i].phySrc1    = `SIZE_PHYSICAL_LOG'($urandom());
      g[i].phySrc2    = `SIZE_PHYSICAL_LOG'($urandom());
      g[i].immediate  = `SIZE_IMMEDIATE'($urandom());
    end
    return g;
  endfunction

  function automatic branchMask_t expectedMask(input branchMask_t m, input logic verified,
                                               input logic [`CHECKPOINTS_LOG-1:0] tag);
    branchMask_t r;
    r = m;
    if (verified) begin
      r[tag] = 1'b0;  // resolved checkpoint no longer pending
    end
    return r;
  endfunction

  task automatic checkPackets(input renamedGroup_t g, input logic verified,
                              input logic [`CHECKPOINTS_LOG-1:0] tag);
    iqPkt_t      expIq;
    alPkt_t      expAl;
    lsqPkt_t     expLsq;
    branchMask_t m;
    logic        ld;
    logic        st;
    int          i;
    for (i = 0; i < `DISPATCH_WIDTH; i++) begin
      m  = expectedMask(g[i].branchMask, verified, tag);
      ld = (g[i].instType == LOAD);
      st = (g[i].instType == STORE);
      expIq = '{instType: g[i].instType, isLoad: ld, isStore: st, branchMask: m,
                ctrlTag: g[i].ctrlTag, phyDest: g[i].phyDest, phySrc1: g[i].phySrc1,
                phySrc2: g[i].phySrc2, immediate: g[i].immediate, pc: g[i].pc};
      expAl = '{isLoad: ld, isStore: st, pc: g[i].pc, logDest: g[i].logDest,
                phyDest: g[i].phyDest, oldPhyDest: g[i].oldPhyDest,
                isBranch: (g[i].instType == BRANCH)};
      expLsq = '{branchMask: m, isStore: st, isLoad: ld};
      checkWord($sformatf("iqPacket_o[%0d]", i), 128'(iqPacket_o[i]), 128'(expIq));
      checkWord($sformatf("alPacket_o[%0d]", i), 128'(alPacket_o[i]), 128'(expAl));
      checkWord($sformatf("lsqPacket_o[%0d]", i), 128'(lsqPacket_o[i]), 128'(expLsq));
    end
  endtask

  //########################################################################
  // stimulus and handshake
  //########################################################################
  task automatic presentGroup(input renamedGroup_t g,
                              input logic [`SIZE_LSQ_LOG:0] ldCnt, stCnt,
                              input logic [`SIZE_ISSUEQ_LOG:0] iqCnt,
                              input logic [`SIZE_ACTIVELIST_LOG:0] alCnt,
                              input logic verified, input logic [`CHECKPOINTS_LOG-1:0] tag,
                              input logic recover);
    @(posedge clk);
    renamedPacket_i   <= g;
    renameReady_i     <= 1'b1;
    loadQueueCnt_i    <= ldCnt;
    storeQueueCnt_i   <= stCnt;
    issueQueueCnt_i   <= iqCnt;
    activeListCnt_i   <= alCnt;
    ctrlVerified_i    <= verified;
    ctrlVerifiedTag_i <= tag;
    flagRecoverEX_i   <= recover;
  endtask

  task automatic expectAccept(input renamedGroup_t g, input logic verified,
                              input logic [`CHECKPOINTS_LOG-1:0] tag);
    int cycles;
    int i;
    @(negedge clk);
    checkBit("backEndReady_o", backEndReady_o, 1'b1);
    checkBit("stallfrontEnd_o", stallfrontEnd_o, 1'b0);
    for (i = 0; i < `DISPATCH_WIDTH; i++) begin
      checkWord($sformatf("updatedBranchMask_o[%0d]", i), 128'(updatedBranchMask_o[i]),
                128'(expectedMask(g[i].branchMask, verified, tag)));
    end
    @(posedge clk);
    renameReady_i   <= 1'b0;  // group taken at this edge
    renamedPacket_i <= '0;    // output register must hold the taken group
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!dispatchValid_o && cycles < validTimeout);
    if (!dispatchValid_o) begin
      $display("Timeout: dispatchValid_o never rose after an accepted group");
      errorCount++;
    end else begin
      checkWord("dispatchValid_o latency", 128'(cycles), 128'(1));
      checkPackets(g, verified, tag);
      @(negedge clk);
      checkBit("dispatchValid_o", dispatchValid_o, 1'b0);  // single-cycle pulse
    end
  endtask

  task automatic expectBlocked(input logic expStall);
    int i;
    for (i = 0; i < 3; i++) begin
      @(negedge clk);
      checkBit("backEndReady_o", backEndReady_o, 1'b0);
      checkBit("stallfrontEnd_o", stallfrontEnd_o, expStall);
      checkBit("dispatchValid_o", dispatchValid_o, 1'b0);
    end
    @(posedge clk);
    renameReady_i <= 1'b0;
  endtask

  //########################################################################
  // directed tests
  //########################################################################
  task automatic testReset();
    @(negedge clk);
    checkBit("dispatchValid_o", dispatchValid_o, 1'b0);
    checkBit("backEndReady_o", backEndReady_o, 1'b0);
  endtask

  task automatic testPlainDispatch();
    grp = makeGroup(ALU, BRANCH, LOAD, STORE);
    presentGroup(grp, 5'd0, 5'd0, 6'd0, 7'd0, 1'b0, 3'd0, 1'b0);
    expectAccept(grp, 1'b0, 3'd0);
  endtask

  task automatic testLoadStoreCapacity();
    grp = makeGroup(LOAD, LOAD, ALU, LOAD);
    presentGroup(grp, 5'd13, 5'd0, 6'd0, 7'd0, 1'b0, 3'd0, 1'b0);
    expectAccept(grp, 1'b0, 3'd0);  // exactly full
    presentGroup(grp, 5'd14, 5'd0, 6'd0, 7'd0, 1'b0, 3'd0, 1'b0);
    expectBlocked(1'b1);
    grp = makeGroup(STORE, ALU, STORE, STORE);
    presentGroup(grp, 5'd0, 5'd13, 6'd0, 7'd0, 1'b0, 3'd0, 1'b0);
    expectAccept(grp, 1'b0, 3'd0);
    presentGroup(grp, 5'd0, 5'd14, 6'd0, 7'd0, 1'b0, 3'd0, 1'b0);
    expectBlocked(1'b1);
  endtask

  task automatic testQueueCapacity();
    grp = makeGroup(ALU, COMPLEX, BRANCH, ALU);
    presentGroup(grp, 5'd0, 5'd0, 6'd28, 7'd0, 1'b0, 3'd0, 1'b0);
    expectAccept(grp, 1'b0, 3'd0);
    presentGroup(grp, 5'd0, 5'd0, 6'd29, 7'd0, 1'b0, 3'd0, 1'b0);
    expectBlocked(1'b1);
    presentGroup(grp, 5'd0, 5'd0, 6'd0, 7'd60, 1'b0, 3'd0, 1'b0);
    expectAccept(grp, 1'b0, 3'd0);
    presentGroup(grp, 5'd0, 5'd0, 6'd0, 7'd61, 1'b0, 3'd0, 1'b0);
    expectBlocked(1'b1);
  endtask

  task automatic testBranchVerify();
    int i;
    grp = makeGroup(BRANCH, LOAD, STORE, ALU);
    for (i = 0; i < `DISPATCH_WIDTH; i++) begin
      grp[i].branchMask[5] = 1'b1;  // every lane depends on checkpoint 5
    end
    presentGroup(grp, 5'd0, 5'd0, 6'd0, 7'd0, 1'b1, 3'd5, 1'b0);
    expectAccept(grp, 1'b1, 3'd5);
    presentGroup(grp, 5'd0, 5'd0, 6'd0, 7'd0, 1'b0, 3'd5, 1'b0);
    expectAccept(grp, 1'b0, 3'd5);
  endtask

  task automatic testRecovery();
    grp = makeGroup(ALU, LOAD, STORE, BRANCH);
    presentGroup(grp, 5'd0, 5'd0, 6'd0, 7'd0, 1'b0, 3'd0, 1'b1);
    expectBlocked(1'b0);
  endtask

  initial begin
    void'($urandom(32'had76));
    errorCount        = 0;
    checkCount        = 0;
    rst_i             = 1'b1;
    renameReady_i     = 1'b0;
    flagRecoverEX_i   = 1'b0;
    ctrlVerified_i    = 1'b0;
    ctrlVerifiedTag_i = '0;
    renamedPacket_i   = '0;
    loadQueueCnt_i    = '0;
    storeQueueCnt_i   = '0;
    issueQueueCnt_i   = '0;
    activeListCnt_i   = '0;
    repeat (8) @(posedge clk);
    rst_i <= 1'b0;
    testReset();
    testPlainDispatch();
    testLoadStoreCapacity();
    testQueueCapacity();
    testBranchVerify();
    testRecovery();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+common
common/dispatchPkg.sv
common/dispatchIf.sv
resourceCheck/resourceCheck.sv
packetFormer/packetFormer.sv
source/dispatchLatch.sv
source/dispatchTop.sv
verif/dispatch_props.sv
verif/dispatchTb.sv

/* run.sh */
#!/bin/sh
# compile and run the dispatch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module dispatchTb \
  -f build.f \
  -o dispatchSim

# the log decides the result, the simulator status is not used
./obj_dir/dispatchSim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "FAIL: testbench reported errors, see sim.log"
  exit 1
fi

# an assertion stop ends the run before the closing line
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "FAIL: simulation ended early, see sim.log"
  exit 1
fi

echo "PASS"
